//--- arcade_game.f
+incdir+verilog
verilog/arcade_pkg.sv
verilog/video_timer.sv
verilog/rom_download.sv
verilog/rom_slot_arbiter.sv
verilog/char_layer.sv
verilog/arcade_game.sv
sim/tb_arcade_game.sv
sim/arcade_game_chk.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator; exit status reports pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f arcade_game.f \
    --top-module tb_arcade_game -o tb_arcade_game \
    && ./obj_dir/tb_arcade_game \
    || exit 1

//--- sim/arcade_game_chk.sv
/* Arcade game core checker
   Download, SDRAM handshake, PROM strobe and blanking rules */
module arcade_game_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 ioctl_wr,
    input logic                 sdram_req,
    input logic                 sdram_ack,
    input logic                 hblank_n,
    input logic                 vblank_n,
    input arcade_pkg::prog_wr_t prog,
    input arcade_pkg::prom_we_t prom_we,
    input logic [3:0]           red,
    input logic [3:0]           green,
    input logic [3:0]           blue
);
    wr_idle: assert property (@(posedge clk) disable iff (rst) ioctl_wr |-> !prog.we)
        else $error("Download byte written while an SDRAM write is pending");

    // Downloader writes and slot reads share one SDRAM ack
    rd_wr_apart: assert property (@(posedge clk) disable iff (rst) !(sdram_req && prog.we))
        else $error("SDRAM read request overlaps a download write");

    prom_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(prom_we))
        else $error("More than one PROM write strobe active");

    req_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("SDRAM read request dropped before ack");

    // Colour must be black outside the visible area
    blank_black: assert property (@(posedge clk) disable iff (rst)
        !(hblank_n && vblank_n) |-> (red == 4'h0 && green == 4'h0 && blue == 4'h0))
        else $error("Colour output not zero during blanking");

endmodule

bind arcade_game arcade_game_chk u_chk (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .ioctl_wr  ( ioctl_wr  ),
    .sdram_req ( sdram_req ),
    .sdram_ack ( sdram_ack ),
    .hblank_n  ( hblank_n  ),
    .vblank_n  ( vblank_n  ),
    .prog      ( prog      ),
    .prom_we   ( prom_we   ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      )
);

//--- sim/tb_arcade_game.sv
/* Arcade game core testbench
   SDRAM model, ROM downloads, frame checks of timing and character pixels,
   and main CPU slot reads */
`include "arcade_game_settings.svh"

module tb_arcade_game;
    import arcade_pkg::*;

    localparam int LIMIT = 3 * 64 * 32 * 4 + 2000;

    logic        clk, rst, ioctl_rom, ioctl_wr, sdram_ack, data_rdy, sdram_req, dwnld_busy;
    logic        hblank_n, vblank_n, hs, vs;
    dl_addr_u    ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic [21:0] sdram_addr, rd_addr;
    logic [15:0] data_read;
    rom_req_t    main_req;
    rom_rsp_t    main_rsp;
    prog_wr_t    prog;
    logic [3:0]  red, green, blue;
    logic [5:0]  h;
    logic [4:0]  v;
    logic [3:0]  pal [3][16];
    integer      seed = 32'h5a055607;
    int          wr_count = 0, main_reads = 0, cycles = 0, lat_cnt;
    logic        rd_busy;

    arcade_game u_arcade_game (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %0h actual %0h", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) stop_on_error("Timeout waiting for the tests to finish");
    end

    // SDRAM model with one ack line for reads and download writes
    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        rd_busy   = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            data_rdy = 1'b0;
            if (rd_busy) begin
                if (lat_cnt == 0) begin
                    data_rdy  = 1'b1;
                    data_read = rd_addr[15:0] ^ 16'hA5C3;
                    rd_busy   = 1'b0;
                end else begin
                    lat_cnt--;
                end
            end
            if (sdram_ack) begin
                sdram_ack = 1'b0;
            end else if (!rst && (sdram_req || prog.we)) begin
                sdram_ack = 1'b1;
                if (prog.we) wr_count++;
                if (sdram_req) begin
                    rd_busy = 1'b1;
                    rd_addr = sdram_addr;
                    lat_cnt = 1 + int'($unsigned($random(seed)) % 4);
                    // Tile reads stay in the first 256 words of the character ROM
                    if (sdram_addr < `CHAR_OFFSET ||
                        sdram_addr >= `CHAR_OFFSET + 22'h100) begin
                        main_reads++;
                    end
                end
            end
        end
    end

    task automatic write_byte(input logic [21:0] addr, input logic [7:0] data);
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
    endtask

    task automatic sdram_download_test();
        logic [21:0] a;
        logic [7:0]  d;
        int          wr0;
        ioctl_rom = 1'b1;
        for (int i = 0; i < 8; i++) begin
            a   = 22'h0_1230 + 22'(i * 37);
            d   = 8'($random(seed));
            wr0 = wr_count;
            write_byte(a, d);
            compare_value("sdram_dl we", 32'd1, 32'(prog.we));
            compare_value("sdram_dl addr", 32'({1'b0, a[21:1]}), 32'(prog.addr));
            compare_value("sdram_dl mask", a[0] ? 32'd2 : 32'd1, 32'(prog.mask));
            compare_value("sdram_dl data", 32'(d), 32'(prog.data));
            compare_value("sdram_dl busy", 32'd1, 32'(dwnld_busy));
            while (prog.we) begin
                @(posedge clk);
                #1;
            end
            compare_value("sdram_dl acks", 32'(wr0 + 1), 32'(wr_count));
        end
        ioctl_rom = 1'b0;
        #1;
        compare_value("sdram_dl busy", 32'd0, 32'(dwnld_busy));
    endtask

    // Select 3 is out of range and must leave all PROMs untouched
    task automatic prom_download_test();
        logic [7:0] d;
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 16; i++) begin
                d = 8'($random(seed));
                if (s < 3) pal[s][i] = d[3:0];
                write_byte(`PROM_START | 22'(s << 8) | 22'(i), d);
                compare_value("prom_dl we", 32'd0, 32'(prog.we));
                compare_value("prom_dl addr", 32'(i), 32'(prog.addr));
                compare_value("prom_dl data", 32'(d[3:0]), 32'(prog.data));
            end
        end
    endtask

    function automatic logic [3:0] pal_index(input logic [4:0] line, input logic [5:0] col);
        logic [15:0] word;
        word = 16'(`CHAR_OFFSET + {14'd0, line, col[5:3]}) ^ 16'hA5C3;
        word = word << {col[2:0], 1'b0};
        return {line[4:3], word[15:14]};
    endfunction

    task automatic next_pixel();
        logic [5:0] last;
        last = h;
        do @(negedge clk); while (h == last);
    endtask

    task automatic check_frame(input string name);
        logic [5:0] eh;
        logic [4:0] ev;
        logic [3:0] idx;
        logic       vis;
        eh = '0;
        ev = '0;
        while (h != 0 || v != 0) next_pixel();
        repeat (64 * 32) begin
            idx = pal_index(ev, eh);
            vis = eh < 6'd48 && ev < 5'd24;
            compare_value({name, " h"}, 32'(eh), 32'(h));
            compare_value({name, " v"}, 32'(ev), 32'(v));
            compare_value({name, " hblank_n"}, 32'(eh < 6'd48), 32'(hblank_n));
            compare_value({name, " vblank_n"}, 32'(ev < 5'd24), 32'(vblank_n));
            compare_value({name, " hs"}, 32'(eh >= 6'd52 && eh < 6'd56), 32'(hs));
            compare_value({name, " vs"}, 32'(ev == 5'd28), 32'(vs));
            compare_value({name, " red"}, vis ? 32'(pal[0][idx]) : 32'd0, 32'(red));
            compare_value({name, " green"}, vis ? 32'(pal[1][idx]) : 32'd0, 32'(green));
            compare_value({name, " blue"}, vis ? 32'(pal[2][idx]) : 32'd0, 32'(blue));
            next_pixel();
            eh = eh + 6'd1;
            if (eh == 6'd0) ev = ev + 5'd1;
        end
    endtask

    task automatic read_main(input logic [17:0] addr);
        int n;
        @(posedge clk);
        #1;
        main_req = '{cs: 1'b1, addr: addr};
        @(negedge clk);
        compare_value("main_miss ok", 32'd0, 32'(main_rsp.ok));
        n = 0;
        while (!main_rsp.ok) begin
            n++;
            if (n > 200) stop_on_error("Main slot read never completed");
            @(negedge clk);
        end
        compare_value("main_read data", 32'(addr[7:0] ^ 8'hC3), 32'(main_rsp.data));
    endtask

    task automatic main_slot_test();
        int reads;
        read_main(18'h0_0123);
        read_main(18'h2_abcd);
        reads = main_reads;
        @(posedge clk);
        #1;
        main_req.cs = 1'b0;
        @(posedge clk);
        #1;
        main_req.cs = 1'b1;
        @(negedge clk);
        compare_value("main_cache ok", 32'd1, 32'(main_rsp.ok));
        compare_value("main_cache data", 32'(8'hcd ^ 8'hC3), 32'(main_rsp.data));
        repeat (40) @(posedge clk);
        compare_value("main_cache reads", 32'(reads), 32'(main_reads));
        #1;
        main_req = '0;
    endtask

    initial begin
        rst        = 1'b1;
        ioctl_rom  = 1'b0;
        ioctl_wr   = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        main_req   = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // No tile fetch runs between the last column and the next prefetch
        while (h != 6'd40) @(negedge clk);
        @(posedge clk);
        #1;
        sdram_download_test();
        prom_download_test();
        check_frame("video_frame");
        fork
            check_frame("video_with_main");
            main_slot_test();
        join
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog/arcade_game.sv
/* Arcade game core top level
   Video timer, ROM downloader, ROM slot controller and character layer.
   The main CPU ROM slot is brought out to ports */
module arcade_game (
    input  logic                 clk,
    input  logic                 rst,
    // ROM download
    input  logic                 ioctl_rom,
    input  logic                 ioctl_wr,
    input  arcade_pkg::dl_addr_u ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    // SDRAM
    output logic                 sdram_req,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    output logic [21:0]          sdram_addr,
    input  logic [15:0]          data_read,
    // Main CPU ROM slot
    input  arcade_pkg::rom_req_t main_req,
    output arcade_pkg::rom_rsp_t main_rsp,
    output arcade_pkg::prog_wr_t prog,
    output logic                 dwnld_busy,
    // Video
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output logic [5:0]           h,
    output logic [4:0]           v,
    output logic                 hblank_n,
    output logic                 vblank_n,
    output logic                 hs,
    output logic                 vs
);
    import arcade_pkg::*;

    logic       pxl_cen;
    logic [5:0] tm_h;
    logic [4:0] tm_v;
    logic       tm_hblank_n;
    logic       tm_vblank_n;
    rom_req_t   char_req;
    rom_rsp_t   char_rsp;
    prom_we_t   prom_we;

    video_timer u_timer (
        .clk      ( clk         ),
        .rst      ( rst         ),
        .pxl_cen  ( pxl_cen     ),
        .hs       ( hs          ),
        .vs       ( vs          ),
        .hblank_n ( tm_hblank_n ),
        .vblank_n ( tm_vblank_n ),
        .h        ( tm_h        ),
        .v        ( tm_v        )
    );

    rom_download u_download (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .ioctl_rom  ( ioctl_rom  ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .sdram_ack  ( sdram_ack  ),
        .prog       ( prog       ),
        .prom_we    ( prom_we    ),
        .dwnld_busy ( dwnld_busy )
    );

    rom_slot_arbiter u_arbiter (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .char_req   ( char_req   ),
        .main_req   ( main_req   ),
        .char_rsp   ( char_rsp   ),
        .main_rsp   ( main_rsp   ),
        .sdram_req  ( sdram_req  ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .sdram_addr ( sdram_addr ),
        .data_read  ( data_read  )
    );

    char_layer u_char (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .hblank_n_in ( tm_hblank_n ),
        .vblank_n_in ( tm_vblank_n ),
        .h_in        ( tm_h        ),
        .v_in        ( tm_v        ),
        .char_req    ( char_req    ),
        .char_rsp    ( char_rsp    ),
        .prog        ( prog        ),
        .prom_we     ( prom_we     ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .h           ( h           ),
        .v           ( v           ),
        .hblank_n    ( hblank_n    ),
        .vblank_n    ( vblank_n    )
    );

endmodule

//--- verilog/arcade_game_settings.svh
/* Arcade game core settings
   Video sizes, pixel divider, SDRAM slot offsets and colour PROM region */
`ifndef ARCADE_GAME_SETTINGS_SVH
`define ARCADE_GAME_SETTINGS_SVH

// Clock cycles per pixel enable
`define PXL_DIV     4

// Horizontal timing, in pixels
`define H_TOTAL     64
`define H_VISIBLE   48
`define HS_START    52
`define HS_LEN      4

// Vertical timing, in lines
`define V_TOTAL     32
`define V_VISIBLE   24
`define VS_LINE     28

// SDRAM word offsets of the ROM slots
`define CHAR_OFFSET 22'h1_8000
`define MAIN_OFFSET 22'h0_0000

// Download addresses from here on go to the colour PROMs
`define PROM_START  22'h3_0000
// Red, green and blue
`define PROM_COUNT  3

`endif

//--- verilog/arcade_pkg.sv
/* Arcade game core types
   ROM slot request and response, SDRAM programming write and the two
   decodings of the download address */
package arcade_pkg;

    // One ROM slot request, word address within the slot
    typedef struct packed {
        logic        cs;
        logic [17:0] addr;
    } rom_req_t;

    // Slot answer, data valid while ok is high
    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } rom_rsp_t;

    // SDRAM write from the downloader, mask bit n enables byte lane n
    typedef struct packed {
        logic        we;
        logic [21:0] addr;
        logic [7:0]  data;
        logic [1:0]  mask;
    } prog_wr_t;

    // Download byte address as SDRAM word plus byte lane
    typedef struct packed {
        logic [20:0] offset;
        logic        bsel;
    } dl_sdram_t;

    // Download byte address inside the PROM region
    typedef struct packed {
        logic [9:0]  region;
        logic [3:0]  prom_sel;
        logic [7:0]  index;
    } dl_prom_t;

    typedef union packed {
        dl_sdram_t sdram_view;
        dl_prom_t  prom_view;
    } dl_addr_u;

    // PROM write strobes: bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] prom_we_t;

endpackage

//--- verilog/char_layer.sv
`include "arcade_game_settings.svh"

/* Character layer
   Fetches each tile row one tile ahead of the beam, shifts out 2-bit pixels
   and colours them through the red, green and blue PROMs */
module char_layer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic                 hblank_n_in,
    input  logic                 vblank_n_in,
    input  logic [5:0]           h_in,
    input  logic [4:0]           v_in,
    output arcade_pkg::rom_req_t char_req,
    input  arcade_pkg::rom_rsp_t char_rsp,
    input  arcade_pkg::prog_wr_t prog,
    input  arcade_pkg::prom_we_t prom_we,
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output logic [5:0]           h,
    output logic [4:0]           v,
    output logic                 hblank_n,
    output logic                 vblank_n
);
    import arcade_pkg::*;

    localparam logic [4:0] V_LAST = 5'(`V_TOTAL - 1);
    localparam logic [2:0] COLS   = 3'(`H_VISIBLE / 8);

    logic [2:0]  next_col;
    logic [4:0]  next_line;
    logic [4:0]  fetch_line;
    logic        tile_start;
    logic [15:0] tile_word;
    logic [15:0] shift;
    logic [1:0]  pix;
    logic [3:0]  pal_idx;
    logic        blank;
    logic [3:0]  pal_mem [`PROM_COUNT][16];

    assign tile_start = h_in[2:0] == 3'd0;
    // Column 7 wraps to column 0 of the next line
    assign next_col   = h_in[5:3] + 3'd1;
    assign next_line  = (v_in == V_LAST) ? 5'd0 : v_in + 5'd1;
    assign fetch_line = (next_col == 3'd0) ? next_line : v_in;

    // A late fetch shows as an empty tile
    assign tile_word = char_rsp.ok ? char_rsp.data : 16'h0000;
    assign pix       = tile_start ? tile_word[15:14] : shift[15:14];
    assign pal_idx   = {v_in[4:3], pix};
    assign blank     = !(hblank_n_in && vblank_n_in);

    // Request the next tile word eight pixels before it is shown
    always_ff @(posedge clk) begin
        if (rst) begin
            char_req <= '0;
        end else if (pxl_cen && tile_start && next_col < COLS) begin
            char_req <= '{cs: 1'b1, addr: 18'({fetch_line, next_col})};
        end
    end

    // Leftmost pixel sits in the top two bits
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (tile_start) begin
                shift <= {tile_word[13:0], 2'b00};
            end else begin
                shift <= {shift[13:0], 2'b00};
            end
        end
    end

    // Colour PROMs loaded by the downloader
    always_ff @(posedge clk) begin
        for (int i = 0; i < `PROM_COUNT; i++) begin
            if (prom_we[i]) begin
                pal_mem[i][prog.addr[3:0]] <= prog.data[3:0];
            end
        end
    end

    // Colour and timing leave together, one pixel after the timer
    always_ff @(posedge clk) begin
        if (rst) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            h        <= '0;
            v        <= '0;
            hblank_n <= 1'b0;
            vblank_n <= 1'b0;
        end else if (pxl_cen) begin
            red      <= blank ? 4'h0 : pal_mem[0][pal_idx];
            green    <= blank ? 4'h0 : pal_mem[1][pal_idx];
            blue     <= blank ? 4'h0 : pal_mem[2][pal_idx];
            h        <= h_in;
            v        <= v_in;
            hblank_n <= hblank_n_in;
            vblank_n <= vblank_n_in;
        end
    end

endmodule

//--- verilog/rom_download.sv
`include "arcade_game_settings.svh"

/* ROM download steering
   Bytes below the PROM region become SDRAM writes held until acknowledged,
   bytes inside it pulse one colour PROM write strobe */
module rom_download (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ioctl_rom,
    input  logic                 ioctl_wr,
    input  arcade_pkg::dl_addr_u ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 sdram_ack,
    output arcade_pkg::prog_wr_t prog,
    output arcade_pkg::prom_we_t prom_we,
    output logic                 dwnld_busy
);
    import arcade_pkg::*;

    logic        is_prom;
    logic        we_r;
    logic [21:0] addr_r;
    logic [7:0]  data_r;
    logic [1:0]  mask_r;

    assign is_prom    = ioctl_addr >= `PROM_START;
    assign dwnld_busy = ioctl_rom;

    assign prog = '{we: we_r, addr: addr_r, data: data_r, mask: mask_r};

    // Write strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            we_r    <= 1'b0;
            prom_we <= '0;
        end else begin
            prom_we <= '0;
            if (ioctl_wr && !is_prom) begin
                we_r <= 1'b1;
            end else if (we_r && sdram_ack) begin
                we_r <= 1'b0;
            end
            // Out of range selects match no strobe
            if (ioctl_wr && is_prom) begin
                for (int i = 0; i < `PROM_COUNT; i++) begin
                    prom_we[i] <= ioctl_addr.prom_view.prom_sel == 4'(i);
                end
            end
        end
    end

    // Address and data of the write
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            if (is_prom) begin
                addr_r <= 22'(ioctl_addr.prom_view.index);
                data_r <= {4'h0, ioctl_dout[3:0]};
                mask_r <= 2'b00;
            end else begin
                addr_r <= 22'(ioctl_addr.sdram_view.offset);
                data_r <= ioctl_dout;
                // Even byte goes to the low lane
                mask_r <= ioctl_addr.sdram_view.bsel ? 2'b10 : 2'b01;
            end
        end
    end

endmodule

//--- verilog/rom_slot_arbiter.sv
`include "arcade_game_settings.svh"

/* ROM slot controller
   Character and main slots share one SDRAM read port. Each slot caches its
   last word and the character slot wins when both miss */
module rom_slot_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  arcade_pkg::rom_req_t char_req,
    input  arcade_pkg::rom_req_t main_req,
    output arcade_pkg::rom_rsp_t char_rsp,
    output arcade_pkg::rom_rsp_t main_rsp,
    output logic                 sdram_req,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    output logic [21:0]          sdram_addr,
    input  logic [15:0]          data_read
);
    import arcade_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_DATA
    } arb_state_e;

    arb_state_e  state;
    rom_req_t    req [2];
    logic [1:0]  hit;
    logic [1:0]  pending;
    logic [1:0]  cache_valid;
    logic [17:0] cache_addr [2];
    logic [15:0] cache_data [2];
    logic [17:0] fetch_addr;
    logic        sel;
    logic        next_sel;
    logic [21:0] next_offset;

    assign req[0] = char_req;
    assign req[1] = main_req;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]     = req[i].cs && cache_valid[i] && (cache_addr[i] == req[i].addr);
            pending[i] = req[i].cs && !hit[i];
        end
    end

    // Fixed priority, char first
    assign next_sel    = !pending[0];
    assign next_offset = next_sel ? `MAIN_OFFSET : `CHAR_OFFSET;

    // Main CPU reads bytes
    assign char_rsp = '{ok: hit[0], data: cache_data[0]};
    assign main_rsp = '{ok: hit[1], data: {8'h00, cache_data[1][7:0]}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ARB_IDLE;
            sdram_req   <= 1'b0;
            cache_valid <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (|pending) begin
                        sdram_req <= 1'b1;
                        state     <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_DATA;
                    end
                end
                ARB_DATA: begin
                    if (data_rdy) begin
                        cache_valid[sel] <= 1'b1;
                        state            <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Fetch address and cached words
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && |pending) begin
            sel        <= next_sel;
            fetch_addr <= req[next_sel].addr;
            sdram_addr <= next_offset + 22'(req[next_sel].addr);
        end
        if (state == ARB_DATA && data_rdy) begin
            cache_addr[sel] <= fetch_addr;
            cache_data[sel] <= data_read;
        end
    end

endmodule

//--- verilog/video_timer.sv
`include "arcade_game_settings.svh"

/* Video timer
   Pixel clock enable, horizontal and vertical counters, blanking and sync */
module video_timer (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,
    output logic       hs,
    output logic       vs,
    output logic       hblank_n,
    output logic       vblank_n,
    output logic [5:0] h,
    output logic [4:0] v
);
    localparam int         DIV_W    = $clog2(`PXL_DIV);
    localparam logic [5:0] H_LAST   = 6'(`H_TOTAL - 1);
    localparam logic [4:0] V_LAST   = 5'(`V_TOTAL - 1);
    localparam logic [5:0] HS_FIRST = 6'(`HS_START);
    localparam logic [5:0] HS_END   = 6'(`HS_START + `HS_LEN);

    logic [DIV_W-1:0] div;
    logic             hs_now;

    // Enable on the last count of the divider
    assign pxl_cen = div == DIV_W'(`PXL_DIV - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            div <= '0;
        end else if (pxl_cen) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    // Blanking follows the counters directly
    assign hblank_n = h < 6'(`H_VISIBLE);
    assign vblank_n = v < 5'(`V_VISIBLE);

    assign hs_now = (h >= HS_FIRST) && (h < HS_END);

    // Sync is registered one pixel late so it lines up with the
    // delayed video from the character layer
    always_ff @(posedge clk) begin
        if (rst) begin
            h  <= '0;
            v  <= '0;
            hs <= 1'b0;
            vs <= 1'b0;
        end else if (pxl_cen) begin
            hs <= hs_now;
            vs <= v == 5'(`VS_LINE);
            if (h == H_LAST) begin
                h <= '0;
                v <= (v == V_LAST) ? '0 : v + 5'd1;
            end else begin
                h <= h + 6'd1;
            end
        end
    end

endmodule
